/* all.f */
+incdir+dv
rtl/cluster_periph_pkg.sv
rtl/periph_bus_if.sv
rtl/periph_bus_demux.sv
rtl/cluster_ctrl_regs.sv
rtl/cluster_timer.sv
rtl/core_sleep_fsm.sv
rtl/cluster_periph_top.sv
dv/tb_cluster_periph.sv

/* Makefile */
# Verilator build and run of the cluster peripheral testbench

VERILATOR ?= verilator
TOP       ?= tb_cluster_periph
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

function automatic logic [ADDR_W-1:0] reg_addr(input logic [SLOT_W-1:0] slot,
                                              input logic [REG_W-1:0] off);
  return (ADDR_W'(slot) << SLOT_LSB) | (ADDR_W'(off) << REG_LSB);
endfunction

task automatic wait_response();
  int cnt;
  cnt = 0;
  @(negedge clk_i);
  while (!periph_r_valid_o && cnt < TIMEOUT_CYC) begin
    @(negedge clk_i);
    cnt++;
  end
  if (!periph_r_valid_o) begin
    $display("Timeout at %0t: no response arrived on the peripheral bus", $time);
    timeouts++;
  end
endtask

task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  @(posedge clk_i);
  periph_req_i   <= 1'b1;
  periph_add_i   <= addr;
  periph_wen_i   <= 1'b0;
  periph_wdata_i <= data;
  @(posedge clk_i);
  periph_req_i <= 1'b0;
  periph_wen_i <= 1'b1;
  wait_response();
endtask

// Mode selects an equality check or an upper bound check
task automatic read_reg(input logic [ADDR_W-1:0] addr, input int mode,
                        input logic [DATA_W-1:0] exp);
  @(posedge clk_i);
  periph_req_i <= 1'b1;
  periph_add_i <= addr;
  periph_wen_i <= 1'b1;
  chk_eq       <= (mode == CHK_EQ);
  chk_le       <= (mode == CHK_LE);
  exp_rdata    <= exp;
  @(posedge clk_i);
  periph_req_i <= 1'b0;
  chk_eq       <= 1'b0;
  chk_le       <= 1'b0;
  wait_response();
endtask

// One-cycle DMA event that may wake cores in the clock enable model
task automatic pulse_dma(input logic [NB_CORES-1:0] bits, input bit wake);
  @(posedge clk_i);
  dma_event_i <= bits;
  @(posedge clk_i);
  dma_event_i <= '0;
  if (wake) begin
    exp_clk_en = exp_clk_en | bits;
  end
endtask

`endif

/* dv/tb_cluster_periph.sv */
`default_nettype none

module tb_cluster_periph;
  timeunit 1ns;
  timeprecision 1ps;
  import cluster_periph_pkg::*;

  localparam int NB_CORES    = 4;
  localparam int TIMEOUT_CYC = 1000;
  localparam int CHK_EQ      = 1;
  localparam int CHK_LE      = 2;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                periph_req_i;
  logic [ADDR_W-1:0]   periph_add_i;
  logic                periph_wen_i;
  logic [DATA_W-1:0]   periph_wdata_i;
  logic                periph_gnt_o;
  logic                periph_r_valid_o;
  logic [DATA_W-1:0]   periph_r_rdata_o;
  logic [NB_CORES-1:0] dma_event_i;
  logic                eoc_o;
  logic [NB_CORES-1:0] fetch_enable_o;
  logic [ADDR_W-1:0]   boot_addr_o;
  logic                busy_o;
  logic                timer_event_o;
  logic [NB_CORES-1:0] core_clk_en_o;

  // Reference models of the outputs and of the read data
  logic                exp_eoc = 1'b0;
  logic [NB_CORES-1:0] exp_fetch = '0;
  logic [ADDR_W-1:0]   exp_boot = BOOT_ADDR_RST;
  logic                exp_busy = 1'b0;
  logic [NB_CORES-1:0] exp_clk_en = '1;
  logic [DATA_W-1:0]   exp_rdata = '0;
  logic                chk_eq = 1'b0;
  logic                chk_le = 1'b0;
  logic [31:0]         lfsr_q = 32'd86998;
  int                  mismatches = 0;
  int                  proto_errs = 0;
  int                  timeouts = 0;

  // Timer event spacing monitor
  logic tmr_mon = 1'b0;
  logic gap_on = 1'b0;
  int   since_evt = 0;
  int   nevt = 0;
  int   exp_gap = 0;

  `include "tb_bus_tasks.svh"

  always #10 clk_i = ~clk_i;

  cluster_periph_top #(.NB_CORES(NB_CORES)) dut_i (.*);

  always @(posedge clk_i) begin
    if (!tmr_mon) begin
      gap_on    <= 1'b0;
      since_evt <= 0;
    end else if (timer_event_o) begin
      gap_on    <= 1'b1;
      since_evt <= 1;
      nevt      <= nevt + 1;
    end else begin
      since_evt <= since_evt + 1;
    end
  end

  // ************************************************************************
  // Checks
  // ************************************************************************
  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_gnt_o == periph_req_i)
    else begin
      proto_errs++;
      $display("At %0t the grant did not follow the request", $time);
    end

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_r_valid_o == $past(periph_req_i && periph_gnt_o))
    else begin
      proto_errs++;
      $display("At %0t the response valid did not come one cycle after a grant", $time);
    end

  a_rd_eq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (periph_req_i && periph_wen_i && chk_eq) |=> (periph_r_rdata_o == exp_rdata))
    else begin
      mismatches++;
      $display("Mismatch at %0t: read data %h, expected %h", $time,
               periph_r_rdata_o, exp_rdata);
    end

  a_rd_le: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (periph_req_i && periph_wen_i && chk_le) |=> (periph_r_rdata_o <= exp_rdata))
    else begin
      mismatches++;
      $display("Mismatch at %0t: read data %h above bound %h", $time,
               periph_r_rdata_o, exp_rdata);
    end

  a_outputs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eoc_o == exp_eoc && fetch_enable_o == exp_fetch && boot_addr_o == exp_boot &&
    busy_o == exp_busy && core_clk_en_o == exp_clk_en && (exp_busy || !timer_event_o))
    else begin
      mismatches++;
      $display("Mismatch at %0t: outputs eoc %b fetch %h boot %h busy %b clk_en %b",
               $time, eoc_o, fetch_enable_o, boot_addr_o, busy_o, core_clk_en_o);
    end

  a_evt_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (timer_event_o && gap_on) |-> (since_evt == exp_gap))
    else begin
      mismatches++;
      $display("Mismatch at %0t: timer event gap %0d, expected %0d", $time,
               since_evt, exp_gap);
    end

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d protocol errors, %0d timeouts",
             mismatches, proto_errs, timeouts);
    if (mismatches == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ************************************************************************
  // Stimulus
  // ************************************************************************
  initial begin
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] cmp;
    int cnt;
    rst_n_i        <= 1'b0;
    periph_req_i   <= 1'b0;
    periph_add_i   <= '0;
    periph_wen_i   <= 1'b1;
    periph_wdata_i <= '0;
    dma_event_i    <= '0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Reset values and control registers
    read_reg(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), CHK_EQ, BOOT_ADDR_RST);
    read_reg(reg_addr(SLOT_CTRL, CTRL_EOC), CHK_EQ, '0);
    read_reg(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), CHK_EQ, '0);
    repeat (3) begin
      d = rand_bits(NB_CORES);
      write_reg(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), d);
      exp_fetch = d[NB_CORES-1:0];
      read_reg(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), CHK_EQ, d);
      d = rand_bits(32);
      write_reg(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), d);
      exp_boot = d;
      read_reg(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), CHK_EQ, d);
    end
    write_reg(reg_addr(SLOT_CTRL, CTRL_EOC), 32'd1);
    exp_eoc = 1'b1;
    read_reg(reg_addr(SLOT_CTRL, CTRL_EOC), CHK_EQ, 32'd1);

    // Unmapped slot and unknown offsets
    read_reg(reg_addr(SLOT_NONE, 4'd0), CHK_EQ, ERR_RDATA);
    read_reg(reg_addr(SLOT_CTRL, 4'd7), CHK_EQ, ERR_RDATA);
    read_reg(reg_addr(SLOT_TIMER, 4'd7), CHK_EQ, ERR_RDATA);
    read_reg(reg_addr(SLOT_EU, 4'd7), CHK_EQ, ERR_RDATA);
    write_reg(reg_addr(SLOT_NONE, CTRL_FETCH_EN), rand_bits(32));
    write_reg(reg_addr(SLOT_CTRL, 4'd7), rand_bits(32));
    read_reg(reg_addr(SLOT_CTRL, CTRL_FETCH_EN), CHK_EQ, DATA_W'(exp_fetch));
    read_reg(reg_addr(SLOT_CTRL, CTRL_BOOT_ADDR), CHK_EQ, exp_boot);

    // Timer with auto-reload
    cmp = 32'd3 + rand_bits(3);
    write_reg(reg_addr(SLOT_TIMER, TMR_CMP), cmp);
    write_reg(reg_addr(SLOT_TIMER, TMR_CFG), 32'd3);
    exp_busy = 1'b1;
    exp_gap  = int'(cmp) + 1;
    tmr_mon  = 1'b1;
    cnt = 0;
    while (nevt < 4 && cnt < TIMEOUT_CYC) begin
      @(negedge clk_i);
      cnt++;
    end
    if (nevt < 4) begin
      $display("Timeout at %0t: timer events did not arrive", $time);
      timeouts++;
    end
    read_reg(reg_addr(SLOT_TIMER, TMR_COUNT), CHK_LE, cmp);
    read_reg(reg_addr(SLOT_TIMER, TMR_COUNT), CHK_LE, cmp);
    tmr_mon = 1'b0;
    write_reg(reg_addr(SLOT_TIMER, TMR_CFG), 32'd0);
    exp_busy = 1'b0;

    // Software event wakes core 0
    write_reg(reg_addr(SLOT_EU, EU_MASK), 32'd1 << EVT_SW);
    write_reg(reg_addr(SLOT_EU, EU_SLEEP), 32'd1);
    exp_clk_en[0] = 1'b0;
    read_reg(reg_addr(SLOT_EU, EU_SLEEP), CHK_EQ, 32'd1);
    write_reg(reg_addr(SLOT_EU, EU_SW_EVT), 32'd1);
    exp_clk_en[0] = 1'b1;

    // DMA events, masked and unmasked, and a cancelled sleep
    write_reg(reg_addr(SLOT_EU, EU_SLEEP), 32'd1);
    exp_clk_en[0] = 1'b0;
    pulse_dma(4'b0001, 1'b0);
    repeat (2) @(posedge clk_i);
    write_reg(reg_addr(SLOT_EU, EU_MASK), (32'd1 << EVT_SW) | (32'd1 << EVT_DMA));
    pulse_dma(4'b0001, 1'b1);
    pulse_dma(4'b0001, 1'b0);
    read_reg(reg_addr(SLOT_EU, EU_PENDING), CHK_EQ, 32'd1);
    write_reg(reg_addr(SLOT_EU, EU_SLEEP), 32'd1);
    read_reg(reg_addr(SLOT_EU, EU_PENDING), CHK_EQ, 32'd0);

    repeat (4) @(posedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

/* rtl/cluster_periph_top.sv */
`default_nettype none

module cluster_periph_top #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  // Peripheral bus from the interconnect
  input  logic                                  periph_req_i,
  input  logic [cluster_periph_pkg::ADDR_W-1:0] periph_add_i,
  input  logic                                  periph_wen_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] periph_wdata_i,
  output logic                                  periph_gnt_o,
  output logic                                  periph_r_valid_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] periph_r_rdata_o,

  input  logic [NB_CORES-1:0]                   dma_event_i,

  output logic                                  eoc_o,
  output logic [NB_CORES-1:0]                   fetch_enable_o,
  output logic [cluster_periph_pkg::ADDR_W-1:0] boot_addr_o,
  output logic                                  busy_o,
  output logic                                  timer_event_o,
  output logic [NB_CORES-1:0]                   core_clk_en_o
);

  logic timer_event;

  periph_bus_if ext_bus ();
  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if eu_bus ();

  assign ext_bus.req   = periph_req_i;
  assign ext_bus.add   = periph_add_i;
  assign ext_bus.wen   = periph_wen_i;
  assign ext_bus.wdata = periph_wdata_i;

  assign periph_gnt_o     = ext_bus.gnt;
  assign periph_r_valid_o = ext_bus.r_valid;
  assign periph_r_rdata_o = ext_bus.r_rdata;

  // ***************************************************************************
  // Address decoder
  // ***************************************************************************
  periph_bus_demux periph_bus_demux_i (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .bus_s   ( ext_bus   ),
    .ctrl_m  ( ctrl_bus  ),
    .timer_m ( timer_bus ),
    .eu_m    ( eu_bus    )
  );

  // ***************************************************************************
  // Register slaves
  // ***************************************************************************
  cluster_ctrl_regs #(
    .NB_CORES ( NB_CORES )
  ) cluster_ctrl_regs_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus_s          ( ctrl_bus       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer cluster_timer_i (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .bus_s         ( timer_bus   ),
    .timer_event_o ( timer_event ),
    .busy_o        ( busy_o      )
  );

  core_sleep_fsm #(
    .NB_CORES ( NB_CORES )
  ) core_sleep_fsm_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .bus_s         ( eu_bus        ),
    .timer_event_i ( timer_event   ),
    .dma_event_i   ( dma_event_i   ),
    .core_clk_en_o ( core_clk_en_o )
  );

  assign timer_event_o = timer_event;

endmodule

`default_nettype wire

/* rtl/core_sleep_fsm.sv */
`default_nettype none

module core_sleep_fsm #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  periph_bus_if.slave         bus_s,
  input  logic                timer_event_i,
  input  logic [NB_CORES-1:0] dma_event_i,
  output logic [NB_CORES-1:0] core_clk_en_o
);
  import cluster_periph_pkg::*;

  localparam logic ST_RUN   = 1'b0;
  localparam logic ST_SLEEP = 1'b1;

  logic [REG_W-1:0]    reg_off;
  logic                wr_en;
  logic [DATA_W-1:0]   rd_data;

  logic [EVT_W-1:0]    mask_q;
  logic [NB_CORES-1:0] sw_evt;
  logic [NB_CORES-1:0] sleep_req;
  logic [NB_CORES-1:0] evt_in;
  logic [NB_CORES-1:0] pending;
  logic [NB_CORES-1:0] sleeping;

  logic                r_valid_q;
  logic [DATA_W-1:0]   r_rdata_q;

  assign bus_s.gnt = bus_s.req;

  assign reg_off = bus_s.add[REG_LSB +: REG_W];
  assign wr_en   = bus_s.req && !bus_s.wen;

  // Per-core bitmaps from the write data
  assign sw_evt    = (wr_en && (reg_off == EU_SW_EVT)) ? bus_s.wdata[NB_CORES-1:0] : '0;
  assign sleep_req = (wr_en && (reg_off == EU_SLEEP)) ? bus_s.wdata[NB_CORES-1:0] : '0;

  // Timer event is broadcast to all cores
  assign evt_in = (sw_evt & {NB_CORES{mask_q[EVT_SW]}})
                | {NB_CORES{timer_event_i && mask_q[EVT_TIMER]}}
                | (dma_event_i & {NB_CORES{mask_q[EVT_DMA]}});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
    end else if (wr_en && (reg_off == EU_MASK)) begin
      mask_q <= bus_s.wdata[EVT_W-1:0];
    end
  end

  // ***************************************************************************
  // One RUN/SLEEP machine per core
  // ***************************************************************************
  for (genvar c = 0; c < NB_CORES; c++) begin : gen_core
    logic state_q;
    logic pend_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= ST_RUN;
        pend_q  <= 1'b0;
      end else begin
        case (state_q)
          ST_RUN: begin
            if (sleep_req[c]) begin
              // Pending or arriving event cancels the sleep and is consumed
              if (!(pend_q || evt_in[c])) begin
                state_q <= ST_SLEEP;
              end
              pend_q <= 1'b0;
            end else begin
              pend_q <= pend_q | evt_in[c];
            end
          end
          default: begin
            // Wake event is consumed, nothing left pending
            if (evt_in[c]) begin
              state_q <= ST_RUN;
            end
          end
        endcase
      end
    end

    assign pending[c]  = pend_q;
    assign sleeping[c] = (state_q == ST_SLEEP);
  end

  assign core_clk_en_o = ~sleeping;

  always_comb begin
    case (reg_off)
      EU_SW_EVT:  rd_data = '0;
      EU_SLEEP:   rd_data = DATA_W'(sleeping);
      EU_PENDING: rd_data = DATA_W'(pending);
      EU_MASK:    rd_data = DATA_W'(mask_q);
      default:    rd_data = ERR_RDATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus_s.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      r_rdata_q <= bus_s.wen ? rd_data : '0;
    end
  end

  assign bus_s.r_valid = r_valid_q;
  assign bus_s.r_rdata = r_rdata_q;

endmodule

`default_nettype wire

/* rtl/cluster_timer.sv */
`default_nettype none

module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  periph_bus_if.slave bus_s,
  output logic        timer_event_o,
  output logic        busy_o
);
  import cluster_periph_pkg::*;

  logic [REG_W-1:0]  reg_off;
  logic              wr_en;
  logic [DATA_W-1:0] rd_data;
  logic              match;

  logic              cfg_en_q;
  logic              cfg_rld_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;

  logic              r_valid_q;
  logic [DATA_W-1:0] r_rdata_q;

  assign bus_s.gnt = bus_s.req;

  assign reg_off = bus_s.add[REG_LSB +: REG_W];
  assign wr_en   = bus_s.req && !bus_s.wen;

  // Compare event only while counting
  assign match = cfg_en_q && (count_q == cmp_q);

  // ***************************************************************************
  // Configuration and counter
  // ***************************************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_en_q  <= 1'b0;
      cfg_rld_q <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
    end else begin
      if (wr_en && (reg_off == TMR_CFG)) begin
        cfg_en_q  <= bus_s.wdata[TMR_CFG_EN];
        cfg_rld_q <= bus_s.wdata[TMR_CFG_RLD];
      end
      if (wr_en && (reg_off == TMR_CMP)) begin
        cmp_q <= bus_s.wdata;
      end
      // A bus write to COUNT wins over counting
      if (wr_en && (reg_off == TMR_COUNT)) begin
        count_q <= bus_s.wdata;
      end else if (match && cfg_rld_q) begin
        count_q <= '0;
      end else if (cfg_en_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_off)
      TMR_CFG:   rd_data = DATA_W'({cfg_rld_q, cfg_en_q});
      TMR_COUNT: rd_data = count_q;
      TMR_CMP:   rd_data = cmp_q;
      default:   rd_data = ERR_RDATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus_s.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      r_rdata_q <= bus_s.wen ? rd_data : '0;
    end
  end

  assign bus_s.r_valid = r_valid_q;
  assign bus_s.r_rdata = r_rdata_q;

  assign timer_event_o = match;
  assign busy_o        = cfg_en_q;

endmodule

`default_nettype wire

/* rtl/cluster_ctrl_regs.sv */
`default_nettype none

module cluster_ctrl_regs #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  periph_bus_if.slave                           bus_s,
  output logic                                  eoc_o,
  output logic [NB_CORES-1:0]                   fetch_enable_o,
  output logic [cluster_periph_pkg::ADDR_W-1:0] boot_addr_o
);
  import cluster_periph_pkg::*;

  logic [REG_W-1:0]    reg_off;
  logic                wr_en;
  logic [DATA_W-1:0]   rd_data;

  logic                eoc_q;
  logic [NB_CORES-1:0] fetch_en_q;
  logic [ADDR_W-1:0]   boot_addr_q;

  logic                r_valid_q;
  logic [DATA_W-1:0]   r_rdata_q;

  // Never stalls
  assign bus_s.gnt = bus_s.req;

  assign reg_off = bus_s.add[REG_LSB +: REG_W];
  assign wr_en   = bus_s.req && !bus_s.wen;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= BOOT_ADDR_RST;
    end else if (wr_en) begin
      case (reg_off)
        CTRL_EOC:       eoc_q       <= bus_s.wdata[0];
        CTRL_FETCH_EN:  fetch_en_q  <= bus_s.wdata[NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_addr_q <= ADDR_W'(bus_s.wdata);
        default: ;
      endcase
    end
  end

  // Read mux
  always_comb begin
    case (reg_off)
      CTRL_EOC:       rd_data = DATA_W'(eoc_q);
      CTRL_FETCH_EN:  rd_data = DATA_W'(fetch_en_q);
      CTRL_BOOT_ADDR: rd_data = DATA_W'(boot_addr_q);
      default:        rd_data = ERR_RDATA;
    endcase
  end

  // Response one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus_s.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_s.req) begin
      r_rdata_q <= bus_s.wen ? rd_data : '0;
    end
  end

  assign bus_s.r_valid = r_valid_q;
  assign bus_s.r_rdata = r_rdata_q;

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

/* rtl/periph_bus_demux.sv */
`default_nettype none

module periph_bus_demux (
  input  logic         clk_i,
  input  logic         rst_n_i,
  periph_bus_if.slave  bus_s,
  periph_bus_if.master ctrl_m,
  periph_bus_if.master timer_m,
  periph_bus_if.master eu_m
);
  import cluster_periph_pkg::*;

  logic [SLOT_W-1:0] req_slot;
  logic              req_accept;
  logic [SLOT_W-1:0] rsp_slot_q;
  logic              rsp_valid_q;
  logic              rsp_write_q;

  assign req_slot   = bus_s.add[SLOT_LSB +: SLOT_W];
  assign req_accept = bus_s.req && bus_s.gnt;

  // Request only reaches the addressed slave
  assign ctrl_m.req  = bus_s.req && (req_slot == SLOT_CTRL);
  assign timer_m.req = bus_s.req && (req_slot == SLOT_TIMER);
  assign eu_m.req    = bus_s.req && (req_slot == SLOT_EU);

  assign ctrl_m.add    = bus_s.add;
  assign ctrl_m.wen    = bus_s.wen;
  assign ctrl_m.wdata  = bus_s.wdata;
  assign timer_m.add   = bus_s.add;
  assign timer_m.wen   = bus_s.wen;
  assign timer_m.wdata = bus_s.wdata;
  assign eu_m.add      = bus_s.add;
  assign eu_m.wen      = bus_s.wen;
  assign eu_m.wdata    = bus_s.wdata;

  // Unmapped slot grants locally
  always_comb begin
    case (req_slot)
      SLOT_CTRL:  bus_s.gnt = ctrl_m.gnt;
      SLOT_TIMER: bus_s.gnt = timer_m.gnt;
      SLOT_EU:    bus_s.gnt = eu_m.gnt;
      default:    bus_s.gnt = bus_s.req;
    endcase
  end

  // Remember where the response comes from
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_slot_q  <= SLOT_NONE;
    end else begin
      rsp_valid_q <= req_accept;
      if (req_accept) begin
        rsp_slot_q <= req_slot;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      rsp_write_q <= !bus_s.wen;
    end
  end

  always_comb begin
    case (rsp_slot_q)
      SLOT_CTRL: begin
        bus_s.r_valid = ctrl_m.r_valid;
        bus_s.r_rdata = ctrl_m.r_rdata;
      end
      SLOT_TIMER: begin
        bus_s.r_valid = timer_m.r_valid;
        bus_s.r_rdata = timer_m.r_rdata;
      end
      SLOT_EU: begin
        bus_s.r_valid = eu_m.r_valid;
        bus_s.r_rdata = eu_m.r_rdata;
      end
      default: begin
        // Error pattern for reads, zero for writes
        bus_s.r_valid = rsp_valid_q;
        bus_s.r_rdata = rsp_write_q ? '0 : ERR_RDATA;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/periph_bus_if.sv */
`default_nettype none

interface periph_bus_if;
  import cluster_periph_pkg::*;

  // Request side, wen low means write
  logic              req;
  logic [ADDR_W-1:0] add;
  logic              wen;
  logic [DATA_W-1:0] wdata;

  // Grant and response side
  logic              gnt;
  logic              r_valid;
  logic [DATA_W-1:0] r_rdata;

  modport master (
    output req, add, wen, wdata,
    input  gnt, r_valid, r_rdata
  );

  modport slave (
    input  req, add, wen, wdata,
    output gnt, r_valid, r_rdata
  );

endinterface

`default_nettype wire

/* rtl/cluster_periph_pkg.sv */
`default_nettype none

package cluster_periph_pkg;

  // ***************************************************************************
  // Bus geometry
  // ***************************************************************************
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Slot field of the address selects one peripheral
  localparam int unsigned NB_SLOTS = 4;
  localparam int unsigned SLOT_W   = $clog2(NB_SLOTS);
  localparam int unsigned SLOT_LSB = 10;

  localparam logic [SLOT_W-1:0] SLOT_CTRL  = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_TIMER = 2'd1;
  localparam logic [SLOT_W-1:0] SLOT_EU    = 2'd2;
  localparam logic [SLOT_W-1:0] SLOT_NONE  = 2'd3;

  // Word offset inside a slot
  localparam int unsigned REG_LSB = 2;
  localparam int unsigned REG_W   = 4;

  // ***************************************************************************
  // Register offsets
  // ***************************************************************************
  localparam logic [REG_W-1:0] CTRL_EOC       = 4'd0;
  localparam logic [REG_W-1:0] CTRL_FETCH_EN  = 4'd1;
  localparam logic [REG_W-1:0] CTRL_BOOT_ADDR = 4'd2;

  localparam logic [REG_W-1:0] TMR_CFG   = 4'd0;
  localparam logic [REG_W-1:0] TMR_COUNT = 4'd1;
  localparam logic [REG_W-1:0] TMR_CMP   = 4'd2;

  // Fields of TMR_CFG
  localparam int unsigned TMR_CFG_EN  = 0;
  localparam int unsigned TMR_CFG_RLD = 1;

  localparam logic [REG_W-1:0] EU_SW_EVT  = 4'd0;
  localparam logic [REG_W-1:0] EU_SLEEP   = 4'd1;
  localparam logic [REG_W-1:0] EU_PENDING = 4'd2;
  localparam logic [REG_W-1:0] EU_MASK    = 4'd3;

  // Event sources, one mask bit each
  localparam int unsigned EVT_SW    = 0;
  localparam int unsigned EVT_TIMER = 1;
  localparam int unsigned EVT_DMA   = 2;
  localparam int unsigned EVT_W     = 3;

  localparam logic [ADDR_W-1:0] BOOT_ADDR_RST = 32'h1C00_0000;
  localparam logic [DATA_W-1:0] ERR_RDATA     = 32'hDEAD_B33F;

endpackage

`default_nettype wire
